/* common/synctimer_defs.svh */
`ifndef SYNCTIMER_DEFS_SVH
`define SYNCTIMER_DEFS_SVH

// time of day counter width in bits
`define SYNC_TIMER_WIDTH    64

// per-node offset estimate width
`define SYNC_OFFSET_WIDTH   24

`define SYNC_MAX_NODES      2

// clock period in ns as a ratio, 10/3 ns for 300 MHz
`define SYNC_NUMERATOR      10
`define SYNC_DENOMINATOR    3

// low-pass filter exponent, weight of new sample is 1/2^(gain+1)
`define SYNC_LPF_GAIN       4

// transmit timestamp latency, two cycles
`define SYNC_TX_CORRECT_NS  6

// flag byte + 8 time bytes + 4 bytes per node
`define SYNC_CMD_LENGTH     (1 + 8 + 4 * `SYNC_MAX_NODES)

`endif

/* common/synctimer_pkg.sv */
`include "synctimer_defs.svh"

package synctimer_pkg;

    typedef enum logic [2:0] {
        SER_IDLE,
        SER_FLAG,
        SER_TIME,
        SER_OFFSET,
        SER_DONE
    } ser_state_e;

    typedef enum logic [2:0] {
        CALC_IDLE,
        CALC_MEASURE,   // between response start and end
        CALC_DELAY,
        CALC_SCALE,
        CALC_UPDATE
    } calc_state_e;

    // which frame field a byte position belongs to
    typedef enum logic [1:0] {
        FIELD_FLAG,
        FIELD_TIME,
        FIELD_OFFSET
    } frame_field_e;

    typedef logic [$clog2(`SYNC_CMD_LENGTH + 1)-1:0] cmd_count_t;
    typedef logic [`SYNC_OFFSET_WIDTH-1:0]            offset_t;
    typedef logic [15:0]                              payload_pos_t;

endpackage

/* project.f */
+incdir+common
common/synctimer_pkg.sv
source/synctimer_timer.sv
synctimer_master/synctimer_offset_calc.sv
synctimer_master/synctimer_cmd_serializer.sv
synctimer_master/synctimer_master.sv
verification/synctimer_checker.sv
verification/tb_synctimer_master.sv

/* run_sim.sh */
#!/bin/sh
# builds the synctimer master testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_synctimer_master
LOG=sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0

/* source/synctimer_timer.sv */
`include "synctimer_defs.svh"

module synctimer_timer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`SYNC_TIMER_WIDTH-1:0] set_time,
    input  logic                         set_valid,
    output logic [`SYNC_TIMER_WIDTH-1:0] current_time
);

    localparam int unsigned TIMER_W  = `SYNC_TIMER_WIDTH;
    localparam int unsigned NUM      = `SYNC_NUMERATOR;
    localparam int unsigned DEN      = `SYNC_DENOMINATOR;
    localparam int unsigned INC_INT  = NUM / DEN;   // whole ns per cycle
    localparam int unsigned INC_FRAC = NUM % DEN;   // leftover in 1/DEN ns
    localparam int unsigned REM_W    = $clog2(2 * DEN);

    logic [REM_W-1:0]   rem_q;
    logic [REM_W-1:0]   rem_sum;
    logic               rem_wrap;
    logic [TIMER_W-1:0] step;

    // fractional part accumulates until it makes a whole ns
    assign rem_sum  = rem_q + REM_W'(INC_FRAC);
    assign rem_wrap = (rem_sum >= REM_W'(DEN));
    assign step     = rem_wrap ? TIMER_W'(INC_INT + 1) : TIMER_W'(INC_INT);

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
            rem_q        <= '0;
        end else if (set_valid) begin
            current_time <= set_time;
            rem_q        <= '0;
        end else begin
            current_time <= current_time + step;
            if (rem_wrap) begin
                rem_q <= rem_sum - REM_W'(DEN);
            end else begin
                rem_q <= rem_sum;
            end
        end
    end

endmodule

/* synctimer_master/synctimer_cmd_serializer.sv */
`include "synctimer_defs.svh"

module synctimer_cmd_serializer (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [`SYNC_TIMER_WIDTH-1:0]                  current_time,
    input  logic [`SYNC_MAX_NODES*`SYNC_OFFSET_WIDTH-1:0] offset_time,
    input  logic                                          cmd_tx_start,
    input  logic                                          cmd_tx_override,
    input  logic                                          cmd_tx_correct,
    output logic [7:0]                                    m_cmd_tx_data,
    output logic                                          m_cmd_tx_last,
    output logic                                          m_cmd_tx_valid,
    input  logic                                          m_cmd_tx_ready
);

    import synctimer_pkg::*;

    localparam int unsigned NODES      = `SYNC_MAX_NODES;
    localparam int unsigned OFS_W      = `SYNC_OFFSET_WIDTH;
    localparam int unsigned TIME_BYTES = `SYNC_TIMER_WIDTH / 8;
    localparam int unsigned OFS_BYTES  = NODES * 4;
    localparam int unsigned TIME_IDX_W = $clog2(TIME_BYTES);
    localparam int unsigned OFS_IDX_W  = $clog2(OFS_BYTES);

    localparam cmd_count_t TIME_LAST  = cmd_count_t'(TIME_BYTES);
    localparam cmd_count_t OFS_FIRST  = cmd_count_t'(1 + TIME_BYTES);
    localparam cmd_count_t FRAME_LAST = cmd_count_t'(`SYNC_CMD_LENGTH - 1);

    ser_state_e   state;
    ser_state_e   state_next;
    frame_field_e field;
    cmd_count_t   count;

    logic [7:0]                 flags_q;
    logic [TIME_BYTES-1:0][7:0] time_q;
    logic [OFS_BYTES-1:0][7:0]  ofs_bytes;
    logic [TIME_IDX_W-1:0]      time_idx;
    logic [OFS_IDX_W-1:0]       ofs_idx;
    logic [7:0]                 byte_sel;
    logic                       cke;

    // output register free or being taken this cycle
    assign cke = !m_cmd_tx_valid || m_cmd_tx_ready;

    assign time_idx = TIME_IDX_W'(count - cmd_count_t'(1));
    assign ofs_idx  = OFS_IDX_W'(count - OFS_FIRST);

    // offsets are live, not latched at start
    always_comb begin
        for (int i = 0; i < NODES; i++) begin
            ofs_bytes[i*4 +: 4] = 32'(offset_time[i*OFS_W +: OFS_W]);
        end
    end

    always_comb begin
        case (state)
            SER_FLAG: field = FIELD_FLAG;
            SER_TIME: field = FIELD_TIME;
            default:  field = FIELD_OFFSET;
        endcase

        case (field)
            FIELD_FLAG: byte_sel = flags_q;
            FIELD_TIME: byte_sel = time_q[time_idx];
            default:    byte_sel = ofs_bytes[ofs_idx];
        endcase
    end

    always_comb begin
        case (state)
            SER_FLAG:   state_next = SER_TIME;
            SER_TIME:   state_next = (count == TIME_LAST) ? SER_OFFSET : SER_TIME;
            SER_OFFSET: state_next = (count == FRAME_LAST) ? SER_DONE : SER_OFFSET;
            default:    state_next = SER_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= SER_IDLE;
            m_cmd_tx_valid <= 1'b0;
            m_cmd_tx_last  <= 1'b0;
        end else if (cmd_tx_start) begin
            state   <= SER_FLAG;   // also restarts a running frame
            count   <= '0;
            flags_q <= {6'd0, cmd_tx_override, cmd_tx_correct};
            time_q  <= current_time;
        end else if (cke) begin
            case (state)
                SER_FLAG, SER_TIME, SER_OFFSET: begin
                    m_cmd_tx_data  <= byte_sel;
                    m_cmd_tx_valid <= 1'b1;
                    m_cmd_tx_last  <= (count == FRAME_LAST);
                    count          <= count + cmd_count_t'(1);
                    state          <= state_next;
                end
                SER_DONE: begin
                    m_cmd_tx_valid <= 1'b0;   // last byte accepted
                    m_cmd_tx_last  <= 1'b0;
                    state          <= state_next;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* synctimer_master/synctimer_master.sv */
`include "synctimer_defs.svh"

module synctimer_master (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`SYNC_TIMER_WIDTH-1:0] set_time,
    input  logic                         set_valid,
    output logic [`SYNC_TIMER_WIDTH-1:0] current_time,
    input  logic                         cmd_tx_start,
    input  logic                         cmd_tx_override,
    input  logic                         cmd_tx_correct,
    output logic [7:0]                   m_cmd_tx_data,
    output logic                         m_cmd_tx_last,
    output logic                         m_cmd_tx_valid,
    input  logic                         m_cmd_tx_ready,
    input  logic                         res_rx_start,
    input  logic                         res_rx_end,
    input  synctimer_pkg::payload_pos_t  res_payload_pos,
    input  logic [7:0]                   res_payload_data,
    input  logic                         res_payload_valid
);

    logic [`SYNC_MAX_NODES*`SYNC_OFFSET_WIDTH-1:0] offset_time;

    synctimer_timer u_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     (set_time),
        .set_valid    (set_valid),
        .current_time (current_time)
    );

    synctimer_offset_calc u_offset_calc (
        .clk               (clk),
        .reset             (reset),
        .current_time      (current_time),
        .cmd_tx_start      (cmd_tx_start),
        .res_rx_start      (res_rx_start),
        .res_rx_end        (res_rx_end),
        .res_payload_pos   (res_payload_pos),
        .res_payload_data  (res_payload_data),
        .res_payload_valid (res_payload_valid),
        .offset_time       (offset_time)
    );

    // next command carries the latest estimates
    synctimer_cmd_serializer u_cmd_serializer (
        .clk             (clk),
        .reset           (reset),
        .current_time    (current_time),
        .offset_time     (offset_time),
        .cmd_tx_start    (cmd_tx_start),
        .cmd_tx_override (cmd_tx_override),
        .cmd_tx_correct  (cmd_tx_correct),
        .m_cmd_tx_data   (m_cmd_tx_data),
        .m_cmd_tx_last   (m_cmd_tx_last),
        .m_cmd_tx_valid  (m_cmd_tx_valid),
        .m_cmd_tx_ready  (m_cmd_tx_ready)
    );

endmodule

/* synctimer_master/synctimer_offset_calc.sv */
`include "synctimer_defs.svh"

module synctimer_offset_calc (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [`SYNC_TIMER_WIDTH-1:0]                   current_time,
    input  logic                                           cmd_tx_start,
    input  logic                                           res_rx_start,
    input  logic                                           res_rx_end,
    input  synctimer_pkg::payload_pos_t                    res_payload_pos,
    input  logic [7:0]                                     res_payload_data,
    input  logic                                           res_payload_valid,
    output logic [`SYNC_MAX_NODES*`SYNC_OFFSET_WIDTH-1:0]  offset_time
);

    import synctimer_pkg::*;

    localparam int unsigned OFS_W    = `SYNC_OFFSET_WIDTH;
    localparam int unsigned NODES    = `SYNC_MAX_NODES;
    localparam int unsigned GAIN     = `SYNC_LPF_GAIN;
    localparam int unsigned RX_BYTES = (OFS_W + 7) / 8;
    localparam int unsigned FILT_W   = OFS_W + GAIN + 2;
    localparam int unsigned OFS_POS  = 9;   // first offset byte in payload

    calc_state_e state;

    offset_t now_ofs;
    offset_t tx_stamp;
    offset_t rx_start_stamp;
    offset_t response_time;
    offset_t packet_time;

    logic [RX_BYTES-1:0][7:0] rx_bytes  [NODES];
    offset_t                  rx_offset [NODES];

    offset_t           delay_time    [NODES];
    offset_t           measured_time [NODES];
    logic [FILT_W-1:0] gain_term     [NODES];
    logic [FILT_W-1:0] filtered      [NODES];
    offset_t           offset_q      [NODES];
    logic              offset_first;

    assign now_ofs = offset_t'(current_time);

    // only the low bits matter, all differences are mod 2^OFS_W
    always_ff @(posedge clk) begin
        if (cmd_tx_start) begin
            tx_stamp <= now_ofs - offset_t'(`SYNC_TX_CORRECT_NS);
        end
        if (res_rx_start) begin
            rx_start_stamp <= now_ofs;
            response_time  <= now_ofs - tx_stamp;
        end
        if (res_rx_end) begin
            packet_time <= now_ofs - rx_start_stamp;
        end
    end

    // offset reported by each node, lsb first
    always_ff @(posedge clk) begin
        if (res_payload_valid) begin
            for (int i = 0; i < NODES; i++) begin
                for (int j = 0; j < RX_BYTES; j++) begin
                    if (res_payload_pos == payload_pos_t'(OFS_POS + 4 * i + j)) begin
                        rx_bytes[i][j] <= res_payload_data;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NODES; i++) begin
            rx_offset[i] = offset_t'(rx_bytes[i]);
            filtered[i]  = (gain_term[i] + FILT_W'(measured_time[i])) >> (GAIN + 1);
            offset_time[i*OFS_W +: OFS_W] = offset_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= CALC_IDLE;
            offset_first <= 1'b1;
            for (int i = 0; i < NODES; i++) begin
                offset_q[i] <= '0;
            end
        end else begin
            case (state)
                CALC_IDLE: begin
                    if (res_rx_start) begin
                        state <= CALC_MEASURE;
                    end
                end
                CALC_MEASURE: begin
                    if (res_rx_end) begin
                        state <= CALC_DELAY;
                    end
                end
                CALC_DELAY: begin
                    for (int i = 0; i < NODES; i++) begin
                        delay_time[i] <= response_time - rx_offset[i];
                    end
                    state <= CALC_SCALE;
                end
                CALC_SCALE: begin
                    for (int i = 0; i < NODES; i++) begin
                        measured_time[i] <= delay_time[i] + offset_t'(packet_time << 1);
                        // old estimate times (2^(gain+1) - 2)
                        gain_term[i] <= (FILT_W'(offset_q[i]) << (GAIN + 1))
                                        - (FILT_W'(offset_q[i]) << 1);
                    end
                    state <= CALC_UPDATE;
                end
                CALC_UPDATE: begin
                    for (int i = 0; i < NODES; i++) begin
                        if (offset_first) begin
                            offset_q[i] <= measured_time[i] >> 1;   // direct load
                        end else begin
                            offset_q[i] <= offset_t'(filtered[i]);
                        end
                    end
                    offset_first <= 1'b0;
                    state        <= CALC_IDLE;
                end
                default: state <= CALC_IDLE;
            endcase
        end
    end

endmodule

/* verification/synctimer_checker.sv */
`include "synctimer_defs.svh"

module synctimer_checker #(
    parameter int N_ROWS = 1
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`SYNC_TIMER_WIDTH-1:0] set_time,
    input  logic                         set_valid,
    input  logic [`SYNC_TIMER_WIDTH-1:0] current_time,
    input  logic                         cmd_tx_start,
    input  logic                         cmd_tx_override,
    input  logic                         cmd_tx_correct,
    input  logic [7:0]                   m_cmd_tx_data,
    input  logic                         m_cmd_tx_last,
    input  logic                         m_cmd_tx_valid,
    input  logic                         m_cmd_tx_ready,
    input  logic                         res_rx_start,
    input  logic                         res_rx_end,
    input  synctimer_pkg::payload_pos_t  res_payload_pos,
    input  logic [7:0]                   res_payload_data,
    input  logic                         res_payload_valid,
    output int                           error_count,
    output int                           frame_count,
    output int                           row_count,
    output logic                         timed_out
);

    timeunit 1ns;
    timeprecision 1ps;

    import synctimer_pkg::*;

    localparam int FRAME_LEN = `SYNC_CMD_LENGTH;
    localparam int NODES     = `SYNC_MAX_NODES;
    localparam int OFS_FIRST = 1 + `SYNC_TIMER_WIDTH / 8;
    localparam int INC_INT   = `SYNC_NUMERATOR / `SYNC_DENOMINATOR;
    localparam int INC_FRAC  = `SYNC_NUMERATOR % `SYNC_DENOMINATOR;
    localparam int FILT_MUL  = (1 << (`SYNC_LPF_GAIN + 1)) - 2;
    localparam int LIMIT     = N_ROWS * 200;

    logic [`SYNC_TIMER_WIDTH-1:0] t_model;
    int      frac;
    logic [7:0] exp_bytes  [FRAME_LEN];
    logic [7:0] rx_payload [FRAME_LEN];
    int      idx;
    bit      frame_active;
    bit      held;
    logic [7:0] held_data;
    offset_t ofs_model [NODES];
    bit      first_rsp;
    offset_t tx_stamp;
    offset_t rx_start_t;
    offset_t response;
    offset_t packet;
    int      row_errors;
    int      cycles = 0;

    assign timed_out = (cycles >= LIMIT);

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        error_count++;
        row_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        error_count++;
        row_errors++;
    endtask

    function automatic frame_field_e field_of(input int pos);
        if (pos == 0) return FIELD_FLAG;
        if (pos < OFS_FIRST) return FIELD_TIME;
        return FIELD_OFFSET;
    endfunction

    // expected bytes of the frame starting now
    task automatic build_frame();
        logic [31:0] word;
        for (int i = 0; i < FRAME_LEN; i++) begin
            case (field_of(i))
                FIELD_FLAG: exp_bytes[i] = {6'd0, cmd_tx_override, cmd_tx_correct};
                FIELD_TIME: exp_bytes[i] = t_model[8*(i-1) +: 8];
                default: begin
                    word = 32'(ofs_model[(i - OFS_FIRST) / 4]);
                    exp_bytes[i] = word[8*((i - OFS_FIRST) % 4) +: 8];
                end
            endcase
        end
    endtask

    task automatic check_stream();
        if (held) begin
            if (!m_cmd_tx_valid) begin
                report_problem("m_cmd_tx_valid dropped while a byte waited for ready");
            end else if (m_cmd_tx_data !== held_data) begin
                report_mismatch("m_cmd_tx_data (held)", m_cmd_tx_data, held_data);
            end
        end
        held      = m_cmd_tx_valid && !m_cmd_tx_ready;
        held_data = m_cmd_tx_data;
        if (m_cmd_tx_valid && !frame_active) begin
            report_problem("m_cmd_tx_valid high with no command frame running");
        end else if (m_cmd_tx_valid && m_cmd_tx_ready) begin
            if (m_cmd_tx_data !== exp_bytes[idx]) begin
                report_mismatch($sformatf("m_cmd_tx_data byte %0d", idx),
                                m_cmd_tx_data, exp_bytes[idx]);
            end
            if (m_cmd_tx_last !== (idx == FRAME_LEN - 1)) begin
                report_mismatch($sformatf("m_cmd_tx_last byte %0d", idx),
                                m_cmd_tx_last, idx == FRAME_LEN - 1);
            end
            idx++;
            if (idx == FRAME_LEN) begin
                frame_active = 1'b0;
                frame_count++;
            end
        end
    endtask

    task automatic update_offsets();
        offset_t     rx_ofs;
        offset_t     measured;
        logic [31:0] acc;
        for (int i = 0; i < NODES; i++) begin
            rx_ofs = offset_t'({rx_payload[OFS_FIRST + 4*i + 3], rx_payload[OFS_FIRST + 4*i + 2],
                                rx_payload[OFS_FIRST + 4*i + 1], rx_payload[OFS_FIRST + 4*i]});
            measured = response - rx_ofs + (packet << 1);
            if (first_rsp) begin
                ofs_model[i] = measured >> 1;
            end else begin
                acc = 32'(ofs_model[i]) * FILT_MUL + 32'(measured);
                ofs_model[i] = offset_t'(acc >> (`SYNC_LPF_GAIN + 1));
            end
        end
        first_rsp = 1'b0;
    endtask

    always @(posedge clk) begin
        string s;
        int    pos_i;
        if (reset) begin
            t_model      = '0;
            frac         = 0;
            frame_active = 1'b0;
            held         = 1'b0;
            first_rsp    = 1'b1;
            for (int i = 0; i < NODES; i++) begin
                ofs_model[i] = '0;
            end
        end else begin
            if (current_time !== t_model) begin
                report_mismatch("current_time", current_time, t_model);
            end
            check_stream();
            if (cmd_tx_start) begin
                build_frame();
                frame_active = 1'b1;
                idx          = 0;
                tx_stamp     = offset_t'(t_model) - offset_t'(`SYNC_TX_CORRECT_NS);
            end
            pos_i = int'(res_payload_pos);
            if (res_payload_valid && pos_i < FRAME_LEN) begin
                rx_payload[pos_i] = res_payload_data;
            end
            if (res_rx_start) begin
                rx_start_t = offset_t'(t_model);
                response   = rx_start_t - tx_stamp;
            end
            if (res_rx_end) begin
                packet = offset_t'(t_model) - rx_start_t;
                update_offsets();
                s = "";
                for (int i = 0; i < NODES; i++) begin
                    s = {s, $sformatf(" %06h", ofs_model[i])};
                end
                $display("row %0d: response %0d ns, packet %0d ns, offsets%s, %0d errors",
                         row_count, response, packet, s, row_errors);
                row_count++;
                row_errors = 0;
            end
            // whole ns per cycle plus carry from the fraction
            if (set_valid) begin
                t_model = set_time;
                frac    = 0;
            end else begin
                frac = frac + INC_FRAC;
                if (frac >= `SYNC_DENOMINATOR) begin
                    frac    = frac - `SYNC_DENOMINATOR;
                    t_model = t_model + 64'(INC_INT + 1);
                end else begin
                    t_model = t_model + 64'(INC_INT);
                end
            end
        end
    end

endmodule

/* verification/tb_synctimer_master.sv */
`include "synctimer_defs.svh"

module tb_synctimer_master;

    timeunit 1ns;
    timeprecision 1ps;

    import synctimer_pkg::*;

    localparam int N_ROWS    = 6;
    localparam int FRAME_LEN = `SYNC_CMD_LENGTH;

    typedef struct packed {
        logic                          load;
        logic [`SYNC_TIMER_WIDTH-1:0]  set_time;
        logic [1:0]                    flags;      // override, correct
        logic [15:0]                   delay;
        logic [15:0]                   pkt_len;    // at least the frame length
        logic [32*`SYNC_MAX_NODES-1:0] node_ofs;   // node 0 in the low word
        logic                          rnd_ready;
    } row_t;

    logic                         clk;
    logic                         reset;
    logic [`SYNC_TIMER_WIDTH-1:0] set_time;
    logic                         set_valid;
    logic [`SYNC_TIMER_WIDTH-1:0] current_time;
    logic                         cmd_tx_start;
    logic                         cmd_tx_override;
    logic                         cmd_tx_correct;
    logic [7:0]                   m_cmd_tx_data;
    logic                         m_cmd_tx_last;
    logic                         m_cmd_tx_valid;
    logic                         m_cmd_tx_ready;
    logic                         res_rx_start;
    logic                         res_rx_end;
    payload_pos_t                 res_payload_pos;
    logic [7:0]                   res_payload_data;
    logic                         res_payload_valid;
    int                           error_count;
    int                           frame_count;
    int                           row_count;
    logic                         timed_out;

    row_t        rows [N_ROWS];
    logic [31:0] rng_state;

    synctimer_master dut (.*);

    synctimer_checker #(.N_ROWS(N_ROWS)) u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] payload_byte(input int pos,
                                                input logic [32*`SYNC_MAX_NODES-1:0] ofs);
        if (pos < 9) return 8'(pos * 37 + 'h5a);   // header filler
        return ofs[8*(pos-9) +: 8];
    endfunction

    task automatic send_command(input logic [1:0] flags, input logic rnd);
        logic done;
        done = 1'b0;
        @(negedge clk);
        cmd_tx_start    = 1'b1;
        cmd_tx_override = flags[1];
        cmd_tx_correct  = flags[0];
        while (!done) begin
            @(negedge clk);
            cmd_tx_start = 1'b0;
            if (rnd) begin
                rng_state      = xorshift32(rng_state);
                m_cmd_tx_ready = rng_state[3];
            end else begin
                m_cmd_tx_ready = 1'b1;
            end
            done = m_cmd_tx_valid && m_cmd_tx_ready && m_cmd_tx_last;
        end
        @(negedge clk);   // last byte taken on the edge before
        m_cmd_tx_ready = 1'b0;
    endtask

    task automatic send_response(input logic [15:0] pkt_len,
                                 input logic [32*`SYNC_MAX_NODES-1:0] ofs);
        @(negedge clk);
        res_rx_start = 1'b1;
        for (int p = 0; p < FRAME_LEN; p++) begin
            @(negedge clk);
            res_rx_start      = 1'b0;
            res_payload_valid = 1'b1;
            res_payload_pos   = payload_pos_t'(p);
            res_payload_data  = payload_byte(p, ofs);
        end
        @(negedge clk);
        res_payload_valid = 1'b0;
        repeat (pkt_len - FRAME_LEN) @(negedge clk);
        res_rx_end = 1'b1;
        @(negedge clk);
        res_rx_end = 1'b0;
    endtask

    initial begin
        @(posedge timed_out);
        $display("timeout: the run hit its cycle limit before the table finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        reset             = 1'b1;
        set_time          = '0;
        set_valid         = 1'b0;
        cmd_tx_start      = 1'b0;
        cmd_tx_override   = 1'b0;
        cmd_tx_correct    = 1'b0;
        m_cmd_tx_ready    = 1'b0;
        res_rx_start      = 1'b0;
        res_rx_end        = 1'b0;
        res_payload_pos   = '0;
        res_payload_data  = '0;
        res_payload_valid = 1'b0;
        rng_state         = 32'h7130_d6e2;

        // load, time, flags, delay, packet, node offsets, random ready
        rows[0] = '{1'b1, 64'h0000_0123_4567_89a0, 2'b00, 16'd4, 16'd20,
                    64'h0000_0020_0000_0010, 1'b0};
        rows[1] = '{1'b0, 64'h0, 2'b01, 16'd8, 16'd24, 64'h0000_0300_0000_0018, 1'b1};
        rows[2] = '{1'b0, 64'h0, 2'b10, 16'd3, 16'd17, 64'h0000_0005_0000_1234, 1'b1};
        rows[3] = '{1'b1, 64'hffff_ffff_ffff_fff0, 2'b11, 16'd6, 16'd30,
                    64'h00ab_cdef_0000_0000, 1'b0};
        rows[4] = '{1'b1, 64'h8000_0000_0000_0001, 2'b01, 16'd10, 16'd19,
                    64'h0000_0040_ffff_fff0, 1'b1};
        rows[5] = '{1'b0, 64'h0, 2'b00, 16'd2, 16'd22, 64'h0000_0077_0000_0077, 1'b1};

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int r = 0; r < N_ROWS; r++) begin
            if (rows[r].load) begin
                @(negedge clk);
                set_time  = rows[r].set_time;
                set_valid = 1'b1;
                @(negedge clk);
                set_valid = 1'b0;
            end
            send_command(rows[r].flags, rows[r].rnd_ready);
            repeat (rows[r].delay) @(negedge clk);
            send_response(rows[r].pkt_len, rows[r].node_ofs);
            repeat (6) @(negedge clk);   // estimates settle 4 cycles after end
        end
        send_command(2'b00, 1'b1);   // carries the final estimates
        repeat (4) @(negedge clk);

        $display("summary: %0d rows, %0d frames, %0d errors", row_count, frame_count, error_count);
        if (error_count == 0 && frame_count == N_ROWS + 1 && row_count == N_ROWS) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
